/* vlog.f */
+incdir+verif
hw/isa_pkg.sv
hw/pipe_pkg.sv
hw/fwd_if.sv
hw/stage_reg.sv
hw/fetch_stage.sv
hw/decode_stage.sv
hw/hazard_unit.sv
hw/execute_stage.sv
hw/memory_stage.sv
hw/cpu_top.sv
verif/cpu_tb.sv

/* verif/asm_helpers.svh */
//********************************************************************
// assembler helpers for the cpu testbench
// rv32i encoders, program loader, debug register read and lcg
//********************************************************************
`ifndef ASM_HELPERS_SVH
`define ASM_HELPERS_SVH

// register-register form with f7 nonzero only for sub
function automatic word_t enc_r(input logic [2:0] f3, input logic [6:0] f7,
                                input reg_idx_t rd, input reg_idx_t rs1, input reg_idx_t rs2);
    return {f7, rs2, rs1, f3, rd, OP};
endfunction

function automatic word_t enc_i(input logic [2:0] f3, input reg_idx_t rd, input reg_idx_t rs1,
                                input word_t imm);
    return {imm[11:0], rs1, f3, rd, OP_IMM};  // low 12 bits of imm
endfunction

function automatic word_t enc_addi(input reg_idx_t rd, input reg_idx_t rs1, input word_t imm);
    return enc_i(F3_ADD_SUB, rd, rs1, imm);
endfunction

function automatic word_t enc_lw(input reg_idx_t rd, input reg_idx_t rs1, input word_t imm);
    return {imm[11:0], rs1, 3'b010, rd, LOAD};
endfunction

function automatic word_t enc_sw(input reg_idx_t rs2, input reg_idx_t rs1, input word_t imm);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], STORE};  // split imm
endfunction

// off counts from the branch pc and beq uses f3 000
function automatic word_t enc_br(input logic [2:0] f3, input reg_idx_t rs1, input reg_idx_t rs2,
                                 input word_t off);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], BRANCH};
endfunction

function automatic word_t enc_jal(input reg_idx_t rd, input word_t off);
    return {off[20], off[10:1], off[11], off[19:12], rd, JAL};
endfunction

function automatic word_t enc_ecall();
    return {25'b0, SYSTEM};
endfunction

// full-period 32-bit lcg
function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
endfunction

// every word gets addi x0 with its own index as a distinct nop
task automatic fill_imem();
    for (int i = 0; i < IMEM_WORDS; i++) begin
        imem_load_en   = 1'b1;
        imem_load_addr = 4 * i;  // byte address
        imem_load_data = enc_addi(0, 0, i);
        step_cycle();
    end
    imem_load_en = 1'b0;
endtask

// program written within the 16 reset cycles
task automatic load_program();
    budget_cycles += 20 * prog.size() + 200;
    reset = 1'b1;
    for (int i = 0; i < 16; i++) begin
        if (i < prog.size()) begin
            imem_load_en   = 1'b1;
            imem_load_addr = 4 * i;
            imem_load_data = prog[i];
        end else begin
            imem_load_en = 1'b0;
        end
        step_cycle();
    end
    imem_load_en = 1'b0;
    reset        = 1'b0;
endtask

// address driven after the edge and value taken at the falling edge
task automatic read_debug_reg(input reg_idx_t idx, output word_t val);
    step_cycle();
    dbg_reg_addr = idx;
    @(negedge clk);
    val = dbg_reg_data;
endtask

`endif

/* verif/cpu_tb.sv */
//********************************************************************
// cpu testbench
// directed programs for alu, memory, branches, jal, ecall and a
// random addi sum, checked through the debug register port
//********************************************************************
`timescale 1ns/10ps
`default_nettype none

module cpu_tb import isa_pkg::*, pipe_pkg::*; ();

    localparam int IMEM_WORDS = 256;
    localparam int DMEM_WORDS = 256;

    logic     clk;
    logic     reset;
    logic     imem_load_en;
    word_t    imem_load_addr;
    word_t    imem_load_data;
    reg_idx_t dbg_reg_addr;
    word_t    dbg_reg_data;
    logic     is_halted;

    word_t       prog [$];                         // program of the current test
    logic [31:0] lcg_state     = 32'h846c;
    int unsigned budget_cycles = IMEM_WORDS + 32;  // grows as programs load

    cpu_top #(.IMEM_WORDS(IMEM_WORDS), .DMEM_WORDS(DMEM_WORDS)) cpu_top_i (
        .clk(clk), .reset(reset),
        .imem_load_en(imem_load_en), .imem_load_addr(imem_load_addr),
        .imem_load_data(imem_load_data),
        .dbg_reg_addr(dbg_reg_addr), .dbg_reg_data(dbg_reg_data), .is_halted(is_halted)
    );

    always #20 clk = ~clk;  // 40 ns period

    // inputs change a little after the rising edge
    task automatic step_cycle();
        @(posedge clk);
        #2;
    endtask

    `include "asm_helpers.svh"

    task automatic run_program();
        load_program();
        do @(negedge clk); while (!is_halted);  // watchdog bounds this
    endtask

    task automatic check_reg(input reg_idx_t idx, input word_t expected, input string what);
        word_t got;
        read_debug_reg(idx, got);
        assert (got === expected) else begin
            $display("mismatch at %0t ns: %s, x%0d is %h, expected %h",
                     $time, what, idx, got, expected);
            $display("TB FAILED");
            $fatal(1, "stopped at first error");
        end
    endtask

    initial begin : watchdog
        int unsigned cycles;
        cycles = 0;
        while (cycles <= budget_cycles) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout, program did not halt within %0d cycles", budget_cycles);
        $display("TB FAILED");
        $fatal(1, "watchdog expired");
    end

    // dependent chain at distance 1, 2 and 3
    task automatic test_alu_chain();
        word_t e [1:13];
        prog.delete();
        prog.push_back(enc_addi(1, 0, 5));
        prog.push_back(enc_addi(2, 0, 12));
        prog.push_back(enc_r(F3_ADD_SUB, 7'b0, 3, 1, 2));
        prog.push_back(enc_r(F3_ADD_SUB, F7_SUB, 4, 1, 3));  // x1 via bypass
        prog.push_back(enc_r(F3_AND, 7'b0, 5, 4, 2));
        prog.push_back(enc_r(F3_OR, 7'b0, 6, 5, 3));
        prog.push_back(enc_r(F3_XOR, 7'b0, 7, 6, 4));
        prog.push_back(enc_r(F3_SLT, 7'b0, 8, 7, 4));
        prog.push_back(enc_r(F3_SLT, 7'b0, 9, 1, 7));  // x7 from mem/wb
        prog.push_back(enc_i(F3_AND, 10, 7, 32'h0f0));
        prog.push_back(enc_i(F3_OR, 11, 10, -256));
        prog.push_back(enc_addi(12, 11, -1));
        prog.push_back(enc_r(F3_ADD_SUB, 7'b0, 13, 12, 12));
        prog.push_back(enc_addi(ECALL_ARG_REG, 0, HALT_CODE));
        prog.push_back(enc_ecall());
        run_program();
        e[1]  = 32'd5;
        e[2]  = 32'd12;
        e[3]  = e[1] + e[2];
        e[4]  = e[1] - e[3];
        e[5]  = e[4] & e[2];
        e[6]  = e[5] | e[3];
        e[7]  = e[6] ^ e[4];
        e[8]  = ($signed(e[7]) < $signed(e[4])) ? 32'd1 : 32'd0;
        e[9]  = ($signed(e[1]) < $signed(e[7])) ? 32'd1 : 32'd0;  // signed compare
        e[10] = e[7] & 32'h0000_00f0;
        e[11] = e[10] | 32'hffff_ff00;                            // imm sign extended
        e[12] = e[11] - 32'd1;
        e[13] = e[12] + e[12];
        for (int i = 1; i <= 13; i++) begin
            check_reg(i, e[i], "alu chain");
        end
    endtask

    task automatic test_memory();
        word_t val;
        val = 32'h5a5;
        prog.delete();
        prog.push_back(enc_addi(1, 0, val));
        prog.push_back(enc_addi(2, 0, 64));     // base address
        prog.push_back(enc_sw(1, 2, 8));
        prog.push_back(enc_lw(3, 2, 8));
        prog.push_back(enc_r(F3_ADD_SUB, 7'b0, 4, 3, 3));  // load-use
        prog.push_back(enc_lw(5, 2, 8));
        prog.push_back(enc_sw(5, 2, 12));       // load-use on store data
        prog.push_back(enc_lw(6, 2, 12));
        prog.push_back(enc_addi(6, 6, 1));
        prog.push_back(enc_addi(ECALL_ARG_REG, 0, HALT_CODE));
        prog.push_back(enc_ecall());
        run_program();
        check_reg(3, val, "load after store");
        check_reg(4, val + val, "load-use add");
        check_reg(5, val, "second load");
        check_reg(6, val + 32'd1, "load-use via store");
    endtask

    // markers x10..x15 show the path taken
    task automatic test_branches();
        prog.delete();
        prog.push_back(enc_addi(1, 0, 7));
        prog.push_back(enc_addi(2, 0, 7));
        prog.push_back(enc_br(3'b000, 1, 2, 12));  // beq taken, 8 -> 20
        prog.push_back(enc_addi(10, 0, 1));
        prog.push_back(enc_addi(11, 0, 1));
        prog.push_back(enc_br(F3_BNE, 1, 2, 8));   // falls through
        prog.push_back(enc_addi(12, 0, 2));
        prog.push_back(enc_addi(3, 0, 9));
        prog.push_back(enc_br(F3_BNE, 1, 3, 12));  // bne taken, 32 -> 44
        prog.push_back(enc_addi(13, 0, 3));
        prog.push_back(enc_addi(14, 0, 3));
        prog.push_back(enc_br(3'b000, 1, 3, 8));   // falls through
        prog.push_back(enc_addi(15, 0, 4));
        prog.push_back(enc_addi(ECALL_ARG_REG, 0, HALT_CODE));
        prog.push_back(enc_ecall());
        run_program();
        check_reg(10, 32'd0, "beq skipped");
        check_reg(11, 32'd0, "beq skipped");
        check_reg(12, 32'd2, "bne fall through");
        check_reg(13, 32'd0, "bne skipped");
        check_reg(14, 32'd0, "bne skipped");
        check_reg(15, 32'd4, "beq fall through");
    endtask

    task automatic test_jal();
        prog.delete();
        prog.push_back(enc_addi(1, 0, 3));
        prog.push_back(enc_jal(5, 16));            // 4 -> 20
        prog.push_back(enc_addi(1, 0, 99));
        prog.push_back(enc_addi(6, 0, 1));
        prog.push_back(enc_addi(7, 0, 1));
        prog.push_back(enc_r(F3_ADD_SUB, 7'b0, 8, 5, 1));
        prog.push_back(enc_jal(9, 8));             // 24 -> 32
        prog.push_back(enc_addi(10, 0, 1));
        prog.push_back(enc_addi(11, 9, 0));
        prog.push_back(enc_addi(ECALL_ARG_REG, 0, HALT_CODE));
        prog.push_back(enc_ecall());
        run_program();
        check_reg(5, 32'd4 + 32'd4, "first link");
        check_reg(1, 32'd3, "skipped overwrite");
        check_reg(6, 32'd0, "skipped marker");
        check_reg(7, 32'd0, "skipped marker");
        check_reg(8, 32'd8 + 32'd3, "link used");
        check_reg(9, 32'd24 + 32'd4, "second link");
        check_reg(10, 32'd0, "skipped marker");
        check_reg(11, 32'd28, "link copied");
    endtask

    task automatic test_ecall();
        prog.delete();
        prog.push_back(enc_addi(ECALL_ARG_REG, 0, 5));
        prog.push_back(enc_ecall());               // a7 is 5, no halt
        prog.push_back(enc_addi(1, 0, 1));
        prog.push_back(enc_addi(ECALL_ARG_REG, 0, HALT_CODE));
        prog.push_back(enc_ecall());               // stalls on a7, then halts
        prog.push_back(enc_addi(2, 0, 1));
        prog.push_back(enc_addi(3, 0, 1));
        prog.push_back(enc_addi(4, 0, 1));
        run_program();
        check_reg(1, 32'd1, "after no-op ecall");
        check_reg(ECALL_ARG_REG, HALT_CODE, "halt code");
        check_reg(2, 32'd0, "after halt");
        check_reg(3, 32'd0, "after halt");
        check_reg(4, 32'd0, "after halt");
    endtask

    task automatic test_random_sum();
        word_t       sum;
        logic [11:0] imm;
        prog.delete();
        sum = '0;
        prog.push_back(enc_addi(1, 0, 0));
        repeat (12) begin
            lcg_state = lcg_next(lcg_state);
            imm       = lcg_state[27:16];          // upper bits, less regular
            sum       = sum + {{20{imm[11]}}, imm};
            prog.push_back(enc_addi(1, 1, {20'b0, imm}));
        end
        prog.push_back(enc_addi(ECALL_ARG_REG, 0, HALT_CODE));
        prog.push_back(enc_ecall());
        run_program();
        check_reg(1, sum, "random addi sum");
    endtask

    initial begin
        clk            = 1'b0;
        reset          = 1'b1;
        imem_load_en   = 1'b0;
        imem_load_addr = '0;
        imem_load_data = '0;
        dbg_reg_addr   = '0;
        step_cycle();
        fill_imem();
        test_alu_chain();
        test_memory();
        test_branches();
        test_jal();
        test_ecall();
        test_random_sum();
        $display("TB PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* hw/cpu_top.sv */
//********************************************************************
// rv32i subset cpu top
// five-stage in-order pipeline with forwarding, load-use stall,
// predict-not-taken control flow and ecall halt
//********************************************************************
`timescale 1ns/10ps
`default_nettype none

module cpu_top import pipe_pkg::*; #(
    parameter int IMEM_WORDS = 256,
    parameter int DMEM_WORDS = 256
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     imem_load_en,    // only honoured during reset
    input  word_t    imem_load_addr,
    input  word_t    imem_load_data,
    input  reg_idx_t dbg_reg_addr,
    output word_t    dbg_reg_data,
    output logic     is_halted
);
    if_id_t  if_d, if_q;
    id_ex_t  id_d, id_q;
    ex_mem_t ex_d, ex_q;
    mem_wb_t wb_d, wb_q;

    logic  stall;       // from hazard unit, also the id/ex bubble
    logic  halt_block;
    logic  halt_req;
    logic  redirect;
    word_t redirect_pc;
    logic  halt_seen;

    fwd_if fwd ();

    fetch_stage #(.IMEM_WORDS(IMEM_WORDS)) fetch_i (
        .clk(clk), .reset(reset), .stall(stall),
        .redirect(redirect), .redirect_pc(redirect_pc), .halt_req(halt_req),
        .load_en(imem_load_en), .load_addr(imem_load_addr), .load_data(imem_load_data),
        .out(if_d)
    );

    // redirect beats stall at if/id
    stage_reg #(.payload_t(if_id_t)) if_id_reg (
        .clk(clk), .reset(reset), .stall(stall && !redirect), .squash(redirect),
        .d(if_d), .q(if_q)
    );

    decode_stage decode_i (
        .clk(clk), .reset(reset), .in(if_q), .wb(wb_q),
        .dbg_addr(dbg_reg_addr), .dbg_data(dbg_reg_data),
        .halt_req(halt_req), .halt_block(halt_block), .out(id_d)
    );

    hazard_unit hazard_i (
        .id_in(if_q), .id_ex(id_q), .ex_mem(ex_q), .mem_wb(wb_q),
        .fwd(fwd.hazard), .stall(stall), .halt_block(halt_block)
    );

    stage_reg #(.payload_t(id_ex_t)) id_ex_reg (
        .clk(clk), .reset(reset), .stall(1'b0), .squash(stall || redirect),
        .d(id_d), .q(id_q)
    );

    execute_stage execute_i (
        .in(id_q), .ex_mem_fwd(ex_q), .mem_wb_fwd(wb_q), .fwd(fwd.execute), .out(ex_d)
    );

    stage_reg #(.payload_t(ex_mem_t)) ex_mem_reg (
        .clk(clk), .reset(reset), .stall(1'b0), .squash(redirect),
        .d(ex_d), .q(ex_q)
    );

    memory_stage #(.DMEM_WORDS(DMEM_WORDS)) memory_i (
        .clk(clk), .in(ex_q), .redirect(redirect), .redirect_pc(redirect_pc), .out(wb_d)
    );

    stage_reg #(.payload_t(mem_wb_t)) mem_wb_reg (
        .clk(clk), .reset(reset), .stall(1'b0), .squash(1'b0),
        .d(wb_d), .q(wb_q)
    );

    // sticky until the next reset
    always_ff @(posedge clk) begin
        if (reset) begin
            halt_seen <= 1'b0;
        end else if (wb_q.valid && wb_q.halt) begin
            halt_seen <= 1'b1;
        end
    end

    assign is_halted = halt_seen || (wb_q.valid && wb_q.halt);

    // fetch freeze plus decode bubbles keep everything after ecall out of wb
    a_no_write_after_halt: assert property (@(posedge clk) disable iff (reset)
        is_halted |-> !(wb_q.valid && wb_q.reg_write));

endmodule

`default_nettype wire

/* hw/memory_stage.sv */
//********************************************************************
// memory stage
// word data memory, redirect on taken branch or jal, writeback mux
//********************************************************************
`timescale 1ns/10ps
`default_nettype none

module memory_stage import pipe_pkg::*; #(
    parameter int DMEM_WORDS = 256
) (
    input  logic    clk,
    input  ex_mem_t in,
    output logic    redirect,
    output word_t   redirect_pc,
    output mem_wb_t out
);
    localparam int AW = $clog2(DMEM_WORDS);

    word_t         dmem [DMEM_WORDS];
    logic [AW-1:0] idx;    // word index, high address bits ignored
    word_t         rdata;
    word_t         wb_val;

    assign idx = in.alu_res[AW+1:2];

    always_ff @(posedge clk) begin
        if (in.valid && in.ctrl.mem_write) begin
            dmem[idx] <= in.store_data;
        end
    end

    assign rdata = dmem[idx];  // async read for lw

    // not-taken was predicted, so taken means mispredict
    assign redirect    = in.valid && in.taken;
    assign redirect_pc = in.target;

    always_comb begin
        if (in.ctrl.mem_read) wb_val = rdata;
        else if (in.ctrl.pc_to_reg) wb_val = in.pc + 32'd4;
        else wb_val = in.alu_res;
    end

    assign out = '{valid: in.valid, rd: in.rd, reg_write: in.ctrl.reg_write, wb_val: wb_val,
                   halt: in.ctrl.halt};

    a_word_aligned: assert property (@(posedge clk)
        in.valid && (in.ctrl.mem_read || in.ctrl.mem_write) |-> in.alu_res[1:0] == 2'b00);

endmodule

`default_nettype wire

/* hw/execute_stage.sv */
//********************************************************************
// execute stage
// operand forwarding, alu, branch compare and target adder
//********************************************************************
`timescale 1ns/10ps
`default_nettype none

module execute_stage import isa_pkg::*, pipe_pkg::*; (
    input  id_ex_t  in,
    input  ex_mem_t ex_mem_fwd,
    input  mem_wb_t mem_wb_fwd,
    fwd_if.execute  fwd,
    output ex_mem_t out
);
    word_t ex_mem_val;  // value ex/mem will write back
    word_t op_a, op_b_reg, op_b;
    word_t alu_res;
    logic  equal, taken;

    function automatic word_t fwd_mux(input fwd_sel_e sel, input word_t reg_val);
        case (sel)
            FROM_EX_MEM: return ex_mem_val;
            FROM_MEM_WB: return mem_wb_fwd.wb_val;
            default:     return reg_val;
        endcase
    endfunction

    assign fwd.ex_rs1 = in.rs1;
    assign fwd.ex_rs2 = in.rs2;

    // jal in ex/mem links pc+4, not its alu result
    assign ex_mem_val = ex_mem_fwd.ctrl.pc_to_reg ? ex_mem_fwd.pc + 32'd4 : ex_mem_fwd.alu_res;

    always_comb begin
        op_a     = fwd_mux(fwd.fwd_a, in.rs1_val);
        op_b_reg = fwd_mux(fwd.fwd_b, in.rs2_val);  // also the store data
    end

    assign op_b = in.ctrl.alu_src ? in.imm : op_b_reg;

    always_comb begin
        case (in.ctrl.alu_op)
            ALU_SUB: alu_res = op_a - op_b;
            ALU_AND: alu_res = op_a & op_b;
            ALU_OR:  alu_res = op_a | op_b;
            ALU_XOR: alu_res = op_a ^ op_b;
            ALU_SLT: alu_res = {31'b0, $signed(op_a) < $signed(op_b)};
            default: alu_res = op_a + op_b;  // add, address calc
        endcase
    end

    assign equal = (op_a == op_b_reg);
    assign taken = in.ctrl.jal || (in.ctrl.branch && (in.ctrl.branch_ne ? !equal : equal));

    assign out = '{valid: in.valid, ctrl: in.ctrl, pc: in.pc, alu_res: alu_res,
                   store_data: op_b_reg, rd: in.rd, taken: taken, target: in.pc + in.imm};

endmodule

`default_nettype wire

/* hw/hazard_unit.sv */
//********************************************************************
// hazard unit
// load-use and ecall stalls, forwarding selects for execute
//********************************************************************
`timescale 1ns/10ps
`default_nettype none

module hazard_unit import isa_pkg::*, pipe_pkg::*; (
    input  if_id_t  id_in,
    input  id_ex_t  id_ex,
    input  ex_mem_t ex_mem,
    input  mem_wb_t mem_wb,
    fwd_if.hazard   fwd,
    output logic    stall,
    output logic    halt_block
);
    logic     id_ecall;
    reg_idx_t id_rs1, id_rs2;
    logic     load_use;
    logic     ex_mem_wr, mem_wb_wr; // stage writes a nonzero rd

    assign ex_mem_wr = ex_mem.valid && ex_mem.ctrl.reg_write && ex_mem.rd != '0;
    assign mem_wb_wr = mem_wb.valid && mem_wb.reg_write && mem_wb.rd != '0;

    // younger result wins
    function automatic fwd_sel_e pick(input reg_idx_t src);
        if (ex_mem_wr && ex_mem.rd == src) return FROM_EX_MEM;
        if (mem_wb_wr && mem_wb.rd == src) return FROM_MEM_WB;
        return FROM_REG;
    endfunction

    always_comb begin
        fwd.fwd_a = pick(fwd.ex_rs1);
        fwd.fwd_b = pick(fwd.ex_rs2);
    end

    // decode sources, same rs1 override as decode
    assign id_ecall = id_in.valid && opcode_e'(id_in.instr[6:0]) == SYSTEM;
    assign id_rs1   = id_ecall ? ECALL_ARG_REG : id_in.instr[RS1_LSB +: 5];
    assign id_rs2   = id_in.instr[RS2_LSB +: 5];

    // load data only exists after mem, one bubble needed
    assign load_use = id_in.valid && id_ex.valid && id_ex.ctrl.mem_read && id_ex.rd != '0
                      && (id_ex.rd == id_rs1 || id_ex.rd == id_rs2);

    // ecall reads a7 in decode, no path from ex/mem there
    assign halt_block = id_ecall
                        && ((id_ex.valid && id_ex.ctrl.reg_write && id_ex.rd == ECALL_ARG_REG)
                            || (ex_mem_wr && ex_mem.rd == ECALL_ARG_REG));

    assign stall = load_use || halt_block;

endmodule

`default_nettype wire

/* hw/decode_stage.sv */
//********************************************************************
// decode stage
// control and immediate decode, register file with write-through
// bypass and debug port, ecall halt detection
//********************************************************************
`timescale 1ns/10ps
`default_nettype none

module decode_stage import isa_pkg::*, pipe_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  if_id_t   in,
    input  mem_wb_t  wb,
    input  reg_idx_t dbg_addr,
    output word_t    dbg_data,
    output logic     halt_req,
    input  logic     halt_block,
    output id_ex_t   out
);
    word_t      regs [1:31];  // x0 not stored
    opcode_e    opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       is_ecall;
    reg_idx_t   rs1, rs2, rd;
    word_t      rs1_val, rs2_val, imm;
    ctrl_t      ctrl;

    // reads see the same-cycle writeback
    function automatic word_t read_reg(input reg_idx_t idx);
        if (idx == '0) return '0;
        if (wb.valid && wb.reg_write && wb.rd == idx) return wb.wb_val;
        return regs[idx];
    endfunction

    function automatic alu_op_e alu_decode(input logic [2:0] f3, input logic sub);
        case (f3)
            F3_ADD_SUB: return sub ? ALU_SUB : ALU_ADD;
            F3_SLT:     return ALU_SLT;
            F3_XOR:     return ALU_XOR;
            F3_OR:      return ALU_OR;
            F3_AND:     return ALU_AND;
            default:    return ALU_ADD;
        endcase
    endfunction

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.valid && wb.reg_write && wb.rd != '0) begin
            regs[wb.rd] <= wb.wb_val;
        end
    end

    assign opcode   = opcode_e'(in.instr[6:0]);
    assign funct3   = in.instr[FUNCT3_LSB +: 3];
    assign funct7   = in.instr[FUNCT7_LSB +: 7];
    assign is_ecall = (opcode == SYSTEM);
    assign rs1      = is_ecall ? ECALL_ARG_REG : in.instr[RS1_LSB +: 5]; // ecall reads a7
    assign rs2      = in.instr[RS2_LSB +: 5];
    assign rd       = in.instr[RD_LSB +: 5];

    always_comb begin
        rs1_val  = read_reg(rs1);
        rs2_val  = read_reg(rs2);
        dbg_data = read_reg(dbg_addr);
    end

    assign halt_req = in.valid && is_ecall && rs1_val == HALT_CODE && !halt_block;

    always_comb begin
        ctrl = '0;  // unknown opcodes become nops
        imm  = '0;
        case (opcode)
            OP: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_op    = alu_decode(funct3, funct7 == F7_SUB);
            end
            OP_IMM: begin
                ctrl.alu_src   = 1'b1;
                ctrl.reg_write = 1'b1;
                ctrl.alu_op    = alu_decode(funct3, 1'b0);  // no subi
                imm            = {{20{in.instr[31]}}, in.instr[31:20]};
            end
            LOAD: begin
                ctrl.alu_src   = 1'b1;
                ctrl.mem_read  = 1'b1;
                ctrl.reg_write = 1'b1;
                imm            = {{20{in.instr[31]}}, in.instr[31:20]};
            end
            STORE: begin
                ctrl.alu_src   = 1'b1;
                ctrl.mem_write = 1'b1;
                imm            = {{20{in.instr[31]}}, in.instr[31:25], in.instr[11:7]};
            end
            BRANCH: begin
                ctrl.branch    = 1'b1;
                ctrl.branch_ne = (funct3 == F3_BNE);
                imm = {{19{in.instr[31]}}, in.instr[31], in.instr[7], in.instr[30:25],
                       in.instr[11:8], 1'b0};
            end
            JAL: begin
                ctrl.jal       = 1'b1;
                ctrl.pc_to_reg = 1'b1;
                ctrl.reg_write = 1'b1;
                imm = {{11{in.instr[31]}}, in.instr[31], in.instr[19:12], in.instr[20],
                       in.instr[30:21], 1'b0};
            end
            SYSTEM:  ctrl.halt = halt_req;  // else ecall is a nop
            default: ;
        endcase
    end

    assign out = '{valid: in.valid, ctrl: ctrl, pc: in.pc, rs1_val: rs1_val, rs2_val: rs2_val,
                   imm: imm, rs1: rs1, rs2: rs2, rd: rd};

endmodule

`default_nettype wire

/* hw/fetch_stage.sv */
//********************************************************************
// fetch stage
// pc, instruction memory with reset-time load port, redirect and
// halt freeze
//********************************************************************
`timescale 1ns/10ps
`default_nettype none

module fetch_stage import pipe_pkg::*; #(
    parameter int IMEM_WORDS = 256
) (
    input  logic   clk,
    input  logic   reset,
    input  logic   stall,
    input  logic   redirect,
    input  word_t  redirect_pc,
    input  logic   halt_req,
    input  logic   load_en,
    input  word_t  load_addr,
    input  word_t  load_data,
    output if_id_t out
);
    localparam int AW = $clog2(IMEM_WORDS);

    word_t imem [IMEM_WORDS];
    word_t pc;
    logic  halted;  // sticky once a halting ecall left decode
    logic  frozen;

    assign frozen = halted || halt_req;

    // program load, byte address in, word index used
    always_ff @(posedge clk) begin
        if (reset && load_en) begin
            imem[load_addr[AW+1:2]] <= load_data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc     <= '0;
            halted <= 1'b0;
        end else if (redirect) begin   // redirect wins over stall and halt
            pc     <= redirect_pc;
            halted <= 1'b0;            // that ecall was on the wrong path
        end else begin
            halted <= frozen;
            if (!stall && !frozen) begin
                pc <= pc + 32'd4;      // predict not taken
            end
        end
    end

    assign out = '{valid: !frozen, instr: imem[pc[AW+1:2]], pc: pc};

    a_load_in_reset: assert property (@(posedge clk) load_en |-> reset);

endmodule

`default_nettype wire

/* hw/stage_reg.sv */
//********************************************************************
// pipeline stage register
// holds on stall, drops the valid bit on squash or reset
//********************************************************************
`timescale 1ns/10ps
`default_nettype none

module stage_reg import pipe_pkg::*; #(
    parameter type payload_t = if_id_t
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     stall,
    input  logic     squash,
    input  payload_t d,
    output payload_t q
);

    always_ff @(posedge clk) begin
        if (reset || squash) begin
            q.valid <= 1'b0;     // rest of payload kept for waveform debug
        end else if (!stall) begin
            q <= d;
        end
    end

    // top level must resolve redirect over stall before it gets here
    a_no_stall_squash: assert property (@(posedge clk) disable iff (reset) !(stall && squash));

endmodule

`default_nettype wire

/* hw/fwd_if.sv */
//********************************************************************
// forwarding interface
// execute publishes its source indices, hazard unit returns selects
//********************************************************************
`timescale 1ns/10ps
`default_nettype none

interface fwd_if import pipe_pkg::*; ();

    reg_idx_t ex_rs1; // sources of the instruction in execute
    reg_idx_t ex_rs2;
    fwd_sel_e fwd_a;  // select for operand a
    fwd_sel_e fwd_b;

    modport execute (output ex_rs1, ex_rs2, input fwd_a, fwd_b);
    modport hazard (input ex_rs1, ex_rs2, output fwd_a, fwd_b);

endinterface

`default_nettype wire

/* hw/pipe_pkg.sv */
//********************************************************************
// pipeline package
// data width, register index, control bundle and the payloads that
// travel between the five stages
//********************************************************************
`default_nettype none

package pipe_pkg;
    import isa_pkg::*;

    localparam int XLEN = 32;

    typedef logic [XLEN-1:0] word_t;
    typedef logic [4:0]      reg_idx_t;

    typedef struct packed {
        logic    alu_src;   // b operand from imm
        logic    mem_read;
        logic    mem_write;
        logic    reg_write;
        logic    pc_to_reg; // link value pc+4
        logic    branch;
        logic    branch_ne; // bne, else beq
        logic    jal;
        logic    halt;      // halting ecall
        alu_op_e alu_op;
    } ctrl_t;

    typedef struct packed {
        logic  valid;
        word_t instr;
        word_t pc;
    } if_id_t;

    typedef struct packed {
        logic     valid;
        ctrl_t    ctrl;
        word_t    pc;
        word_t    rs1_val;
        word_t    rs2_val;
        word_t    imm;
        reg_idx_t rs1;
        reg_idx_t rs2;
        reg_idx_t rd;
    } id_ex_t;

    typedef struct packed {
        logic     valid;
        ctrl_t    ctrl;
        word_t    pc;
        word_t    alu_res;    // also the memory address
        word_t    store_data;
        reg_idx_t rd;
        logic     taken;      // branch taken or jal
        word_t    target;
    } ex_mem_t;

    typedef struct packed {
        logic     valid;
        reg_idx_t rd;
        logic     reg_write;
        word_t    wb_val;
        logic     halt;
    } mem_wb_t;

    // operand source for the execute muxes
    typedef enum logic [1:0] {FROM_REG, FROM_EX_MEM, FROM_MEM_WB} fwd_sel_e;

endpackage

`default_nettype wire

/* hw/isa_pkg.sv */
//********************************************************************
// isa package
// rv32i subset encodings: opcodes, funct fields, field positions,
// alu operations and the ecall halt convention
//********************************************************************
`default_nettype none

package isa_pkg;

    // major opcodes of the kept instruction classes
    typedef enum logic [6:0] {
        OP     = 7'b0110011, // register-register alu
        OP_IMM = 7'b0010011, // addi/andi/ori
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011, // beq/bne
        JAL    = 7'b1101111,
        SYSTEM = 7'b1110011  // ecall only
    } opcode_e;

    // funct3 variants
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;
    localparam logic [2:0] F3_BNE     = 3'b001; // beq is 000
    localparam logic [6:0] F7_SUB     = 7'b0100000;

    // lsb positions of the instruction fields
    localparam int RD_LSB     = 7;
    localparam int FUNCT3_LSB = 12;
    localparam int RS1_LSB    = 15;
    localparam int RS2_LSB    = 20;
    localparam int FUNCT7_LSB = 25;

    typedef enum logic [2:0] {ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT} alu_op_e;

    // ecall halts when a7 (x17) holds 10
    localparam logic [4:0]  ECALL_ARG_REG = 5'd17;
    localparam int unsigned HALT_CODE     = 10;

endpackage

`default_nettype wire
